//--- common/csr_pkg.sv
// CSR widths, address and operation enums, field masks and identification constants
package csr_pkg;

    // Datapath and field widths
    localparam int XLEN       = 64;             // Hart data width
    localparam int HART_ID_W  = 1;              // Two harts
    localparam int FUNCT3_W   = 3;              // Zicsr funct3 field
    localparam int CSR_ADDR_W = 12;             // CSR address field
    localparam int REG_IDX_W  = 5;              // rs1 index / zimm field

    // Top two address bits of 11 mark a read-only CSR
    localparam logic [1:0] CSR_RO_TOP = 2'b11;

    // Implemented machine-mode CSR addresses
    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_ADDR_MSTATUS   = 12'h300,           // Machine status
        CSR_ADDR_MISA      = 12'h301,           // ISA and extensions
        CSR_ADDR_MIE       = 12'h304,           // Machine interrupt enable
        CSR_ADDR_MTVEC     = 12'h305,           // Trap vector base
        CSR_ADDR_MSCRATCH  = 12'h340,           // Scratch
        CSR_ADDR_MEPC      = 12'h341,           // Exception PC
        CSR_ADDR_MCAUSE    = 12'h342,           // Trap cause
        CSR_ADDR_MTVAL     = 12'h343,           // Trap value
        CSR_ADDR_MCYCLE    = 12'hB00,           // Cycle counter
        CSR_ADDR_MINSTRET  = 12'hB02,           // Retired instructions
        CSR_ADDR_MVENDORID = 12'hF11,           // Vendor ID
        CSR_ADDR_MARCHID   = 12'hF12,           // Architecture ID
        CSR_ADDR_MIMPID    = 12'hF13,           // Implementation ID
        CSR_ADDR_MHARTID   = 12'hF14            // Hart ID
    } csr_addr_t;

    // Read-modify-write operation after decode
    typedef enum logic [1:0] {
        CSR_OP_RW   = 2'b00,                    // Write operand
        CSR_OP_RS   = 2'b01,                    // Set operand bits
        CSR_OP_RC   = 2'b10,                    // Clear operand bits
        CSR_OP_NONE = 2'b11                     // No CSR operation
    } csr_op_t;

    // mstatus field positions
    localparam int MSTATUS_MIE_BIT  = 3;        // Global interrupt enable
    localparam int MSTATUS_MPIE_BIT = 7;        // Previous MIE
    localparam int MSTATUS_MPP_LSB  = 11;       // Previous privilege, 2 bits

    // mie field positions
    localparam int MIE_MSIE_BIT = 3;            // Software interrupt
    localparam int MIE_MTIE_BIT = 7;            // Timer interrupt
    localparam int MIE_MEIE_BIT = 11;           // External interrupt

    // Writable bits of mstatus, evaluates to 0x1888
    localparam logic [XLEN-1:0] MSTATUS_MASK = (64'd1 << MSTATUS_MIE_BIT)
                                             | (64'd1 << MSTATUS_MPIE_BIT)
                                             | (64'd3 << MSTATUS_MPP_LSB);

    // Writable bits of mie, evaluates to 0x888
    localparam logic [XLEN-1:0] MIE_MASK = (64'd1 << MIE_MSIE_BIT)
                                         | (64'd1 << MIE_MTIE_BIT)
                                         | (64'd1 << MIE_MEIE_BIT);

    // Alignment masks applied on write
    localparam logic [XLEN-1:0] MTVEC_WMASK = ~64'h1;   // Bit 0 forced low
    localparam logic [XLEN-1:0] MEPC_WMASK  = ~64'h3;   // IALIGN=32

    // misa with MXL=2 (RV64), I (bit 8) and U (bit 20)
    localparam logic [XLEN-1:0] MISA_VALUE = 64'h8000_0000_0010_0100;

    // Identification constants
    localparam logic [XLEN-1:0] MVENDORID_VALUE = 64'h0000_0000_0000_0000; // Non-commercial
    localparam logic [XLEN-1:0] MARCHID_VALUE   = 64'h0000_0000_0000_5a17;
    localparam logic [XLEN-1:0] MIMPID_VALUE    = 64'h0000_0000_0001_0000; // Rev 1.0

endpackage

//--- common/csr_req_if.sv
// Decoded CSR request interface with decode and execute modports
`timescale 1ns/100ps

interface csr_req_if import csr_pkg::*; ();

    logic                  valid;               // Request present this cycle
    csr_op_t               op;                  // RW, RS, RC or none
    logic [CSR_ADDR_W-1:0] addr;                // Raw CSR address
    logic [XLEN-1:0]       operand;             // rs1 value or zimm
    logic                  wr_en;               // Legal request with write intent
    logic                  illegal;             // Valid request that traps

    // Decode stage drives the request
    modport dec (
        output valid,
        output op,
        output addr,
        output operand,
        output wr_en,
        output illegal
    );

    // ALU, register file and result stage only observe it
    modport exe (
        input valid,
        input op,
        input addr,
        input operand,
        input wr_en,
        input illegal
    );

endinterface

//--- src/csr_decode.sv
// CSR instruction decoder producing operation, operand, write intent and legality
`timescale 1ns/100ps

module csr_decode import csr_pkg::*; (
    input  logic                  valid_i,      // Instruction strobe
    input  logic [FUNCT3_W-1:0]   funct3_i,     // Zicsr funct3
    input  logic [CSR_ADDR_W-1:0] csr_addr_i,   // CSR address
    input  logic [REG_IDX_W-1:0]  rs1_idx_i,    // rs1 index or zimm
    input  logic [XLEN-1:0]       rs1_data_i,   // rs1 register value
    csr_req_if.dec                req_o         // Decoded request
);

    csr_op_t op;                                // Operation from funct3
    logic    addr_known;                        // Address is implemented
    logic    addr_ro;                           // Read-only address space
    logic    wr_intent;                         // Instruction wants a write
    logic    bad_funct3;                        // funct3 0 or 4
    logic    illegal_cond;                      // Any illegal condition

    // funct3[1:0] picks the operation, funct3[2] the immediate form
    always_comb begin
        case (funct3_i[1:0])
            2'b01:   op = CSR_OP_RW;
            2'b10:   op = CSR_OP_RS;
            2'b11:   op = CSR_OP_RC;
            default: op = CSR_OP_NONE;          // SYSTEM non-CSR encodings
        endcase
    end

    // Only the implemented CSRs decode
    always_comb begin
        case (csr_addr_i)
            CSR_ADDR_MSTATUS, CSR_ADDR_MISA, CSR_ADDR_MIE, CSR_ADDR_MTVEC,
            CSR_ADDR_MSCRATCH, CSR_ADDR_MEPC, CSR_ADDR_MCAUSE, CSR_ADDR_MTVAL,
            CSR_ADDR_MCYCLE, CSR_ADDR_MINSTRET,
            CSR_ADDR_MVENDORID, CSR_ADDR_MARCHID, CSR_ADDR_MIMPID,
            CSR_ADDR_MHARTID: addr_known = 1'b1;
            default:          addr_known = 1'b0;
        endcase
    end

    assign addr_ro    = (csr_addr_i[CSR_ADDR_W-1 -: 2] == CSR_RO_TOP);
    assign bad_funct3 = (op == CSR_OP_NONE);

    // RS and RC with rs1/zimm zero are pure reads
    assign wr_intent = (op == CSR_OP_RW)
                    || ((op != CSR_OP_NONE) && (rs1_idx_i != '0));

    assign illegal_cond = bad_funct3 || !addr_known || (wr_intent && addr_ro);

    assign req_o.valid   = valid_i;
    assign req_o.op      = op;
    assign req_o.addr    = csr_addr_i;
    assign req_o.operand = funct3_i[2] ? {{(XLEN-REG_IDX_W){1'b0}}, rs1_idx_i}  // zimm
                                       : rs1_data_i;
    assign req_o.wr_en   = wr_intent && !illegal_cond;
    assign req_o.illegal = valid_i && illegal_cond;

    // A trapping instruction must never reach the register file
    a_no_wr_on_illegal: assert final (!(req_o.illegal && req_o.wr_en))
        else $error("illegal CSR request carries a write enable");

endmodule

//--- csr_regs/csr_regs.sv
// CSR storage with write masking, cycle and retire counters and read multiplexer
`timescale 1ns/100ps

module csr_regs import csr_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    csr_req_if.exe               req_i,         // Address of current request
    input  logic [HART_ID_W-1:0] hartid_i,      // Hart running this unit
    input  logic                 instret_i,     // Retire pulse
    input  logic                 wr_strobe_i,   // Write from ALU
    input  logic [XLEN-1:0]      wr_data_i,     // New CSR value
    output logic [XLEN-1:0]      old_data_o     // Current CSR value
);

    logic [XLEN-1:0] mstatus_q;                 // Only MIE, MPIE, MPP live
    logic [XLEN-1:0] mie_q;                     // Only MSIE, MTIE, MEIE live
    logic [XLEN-1:0] mtvec_q;                   // Trap vector base and mode
    logic [XLEN-1:0] mscratch_q;                // Free for software
    logic [XLEN-1:0] mepc_q;                    // Word aligned
    logic [XLEN-1:0] mcause_q;                  // Trap cause
    logic [XLEN-1:0] mtval_q;                   // Trap value
    logic [XLEN-1:0] mcycle_q;                  // Cycle counter
    logic [XLEN-1:0] minstret_q;                // Retire counter

    logic wr_mcycle;                            // Counter write this cycle
    logic wr_minstret;

    assign wr_mcycle   = wr_strobe_i && (req_i.addr == CSR_ADDR_MCYCLE);
    assign wr_minstret = wr_strobe_i && (req_i.addr == CSR_ADDR_MINSTRET);

    // Writable CSRs take effect at the next edge
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else if (wr_strobe_i) begin
            case (req_i.addr)
                CSR_ADDR_MSTATUS:  mstatus_q  <= wr_data_i & MSTATUS_MASK;
                CSR_ADDR_MIE:      mie_q      <= wr_data_i & MIE_MASK;
                CSR_ADDR_MTVEC:    mtvec_q    <= wr_data_i & MTVEC_WMASK;
                CSR_ADDR_MSCRATCH: mscratch_q <= wr_data_i;
                CSR_ADDR_MEPC:     mepc_q     <= wr_data_i & MEPC_WMASK;
                CSR_ADDR_MCAUSE:   mcause_q   <= wr_data_i;
                CSR_ADDR_MTVAL:    mtval_q    <= wr_data_i;
                default: ;                      // misa is WARL, counters below
            endcase
        end
    end

    // Counters run every cycle, a write wins over the increment
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            if (wr_mcycle) begin
                mcycle_q <= wr_data_i;
            end else begin
                mcycle_q <= mcycle_q + 64'd1;
            end

            if (wr_minstret) begin
                minstret_q <= wr_data_i;
            end else if (instret_i) begin
                minstret_q <= minstret_q + 64'd1;
            end
        end
    end

    // Read path is combinational so the result stage sees the pre-write value
    always_comb begin
        case (req_i.addr)
            CSR_ADDR_MSTATUS:   old_data_o = mstatus_q;
            CSR_ADDR_MISA:      old_data_o = MISA_VALUE;
            CSR_ADDR_MIE:       old_data_o = mie_q;
            CSR_ADDR_MTVEC:     old_data_o = mtvec_q;
            CSR_ADDR_MSCRATCH:  old_data_o = mscratch_q;
            CSR_ADDR_MEPC:      old_data_o = mepc_q;
            CSR_ADDR_MCAUSE:    old_data_o = mcause_q;
            CSR_ADDR_MTVAL:     old_data_o = mtval_q;
            CSR_ADDR_MCYCLE:    old_data_o = mcycle_q;      // Count in this cycle
            CSR_ADDR_MINSTRET:  old_data_o = minstret_q;
            CSR_ADDR_MVENDORID: old_data_o = MVENDORID_VALUE;
            CSR_ADDR_MARCHID:   old_data_o = MARCHID_VALUE;
            CSR_ADDR_MIMPID:    old_data_o = MIMPID_VALUE;
            CSR_ADDR_MHARTID:   old_data_o = {{(XLEN-HART_ID_W){1'b0}}, hartid_i};
            default:            old_data_o = '0;           // Unknown, trapped in decode
        endcase
    end

    // Decode legality must keep the ALU strobe off read-only space
    a_no_ro_write: assert property (
        @(posedge clk_i) disable iff (rst_i)
        wr_strobe_i |-> (req_i.addr[CSR_ADDR_W-1 -: 2] != CSR_RO_TOP)
    ) else $error("write strobe to read-only CSR %h", req_i.addr);

endmodule

//--- src/csr_alu.sv
// CSR read-modify-write datapath producing the new value and write strobe
`timescale 1ns/100ps

module csr_alu import csr_pkg::*; (
    csr_req_if.exe          req_i,              // Decoded request
    input  logic [XLEN-1:0] old_data_i,         // Value before the write
    output logic            wr_strobe_o,        // Write this cycle
    output logic [XLEN-1:0] wr_data_o           // Value to store
);

    // New value per Zicsr semantics
    always_comb begin
        case (req_i.op)
            CSR_OP_RW: wr_data_o = req_i.operand;
            CSR_OP_RS: wr_data_o = old_data_i | req_i.operand;
            CSR_OP_RC: wr_data_o = old_data_i & ~req_i.operand;
            default:   wr_data_o = old_data_i;  // No change
        endcase
    end

    // wr_en already excludes illegal and read-only cases
    assign wr_strobe_o = req_i.valid && req_i.wr_en;

endmodule

//--- src/csr_result.sv
// CSR result register for done, returned old value and illegal flag
`timescale 1ns/100ps

module csr_result import csr_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    csr_req_if.exe          req_i,              // Request in execute
    input  logic [XLEN-1:0] old_data_i,         // CSR value before write
    output logic            done_o,             // One cycle after valid
    output logic [XLEN-1:0] rdata_o,            // Old CSR value
    output logic            illegal_o           // Instruction traps
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            done_o    <= 1'b0;
            illegal_o <= 1'b0;
            rdata_o   <= '0;
        end else begin
            done_o    <= req_i.valid;
            illegal_o <= req_i.illegal;
            // Trapping instructions return zero
            rdata_o   <= (req_i.valid && !req_i.illegal) ? old_data_i : '0;
        end
    end

    // Every request completes exactly one cycle later, back-to-back included
    a_done_follows_valid: assert property (
        @(posedge clk_i) disable iff (rst_i)
        req_i.valid |=> done_o
    ) else $error("done_o missing one cycle after valid");

    a_no_spurious_done: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !req_i.valid |=> !done_o
    ) else $error("done_o without a request");

endmodule

//--- src/csr_unit.sv
// CSR unit top level joining decode, register file, ALU and result stage
`timescale 1ns/100ps

module csr_unit import csr_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  valid_i,      // CSR instruction strobe
    input  logic [FUNCT3_W-1:0]   funct3_i,     // Zicsr funct3
    input  logic [CSR_ADDR_W-1:0] csr_addr_i,   // CSR address
    input  logic [REG_IDX_W-1:0]  rs1_idx_i,    // rs1 index or zimm
    input  logic [XLEN-1:0]       rs1_data_i,   // rs1 value
    input  logic [HART_ID_W-1:0]  hartid_i,     // Hart ID for mhartid
    input  logic                  instret_i,    // Retire pulse for minstret
    output logic                  done_o,       // Result strobe
    output logic [XLEN-1:0]       rdata_o,      // Old CSR value
    output logic                  illegal_o     // Illegal instruction
);

    logic [XLEN-1:0] old_data;                  // Current CSR value
    logic            wr_strobe;                 // ALU write request
    logic [XLEN-1:0] wr_data;                   // ALU write value

    csr_req_if req_if ();                       // Decoded request bundle

    csr_decode i_csr_decode (
        .valid_i    (valid_i),
        .funct3_i   (funct3_i),
        .csr_addr_i (csr_addr_i),
        .rs1_idx_i  (rs1_idx_i),
        .rs1_data_i (rs1_data_i),
        .req_o      (req_if.dec)
    );

    csr_regs i_csr_regs (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (req_if.exe),
        .hartid_i    (hartid_i),
        .instret_i   (instret_i),
        .wr_strobe_i (wr_strobe),
        .wr_data_i   (wr_data),
        .old_data_o  (old_data)
    );

    csr_alu i_csr_alu (
        .req_i       (req_if.exe),
        .old_data_i  (old_data),
        .wr_strobe_o (wr_strobe),
        .wr_data_o   (wr_data)
    );

    csr_result i_csr_result (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_i      (req_if.exe),
        .old_data_i (old_data),
        .done_o     (done_o),
        .rdata_o    (rdata_o),
        .illegal_o  (illegal_o)
    );

endmodule

//--- bench/tb_csr_tasks.svh
// Stimulus tasks, LFSR random source and CSR reference model for the CSR unit testbench

// Galois LFSR, one step per bit taken, taps 32 30 26 25
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
        v = {v[62:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
    end
    return v;
endfunction

// Implemented machine-mode addresses
function automatic logic is_known(input logic [11:0] addr);
    case (addr)
        12'h300, 12'h301, 12'h304, 12'h305, 12'h340, 12'h341, 12'h342, 12'h343,
        12'hB00, 12'hB02, 12'hF11, 12'hF12, 12'hF13, 12'hF14: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic logic has_intent(input logic [2:0] f3, input logic [4:0] idx);
    return (f3[1:0] == 2'b01) || ((f3[1:0] != 2'b00) && (idx != 5'd0));
endfunction

function automatic logic expect_illegal(input logic [2:0] f3, input logic [11:0] addr,
                                        input logic [4:0] idx);
    logic ro;
    ro = (addr[11:10] == 2'b11);                // Read-only space
    return (f3[1:0] == 2'b00) || !is_known(addr) || (has_intent(f3, idx) && ro);
endfunction

function automatic logic [63:0] read_model(input logic [11:0] addr);
    if (addr == 12'hF14) begin
        return {63'd0, hartid};                 // Zero-extended hart ID
    end
    return shadow[addr];
endfunction

// Masking and WARL rules on write
task automatic write_model(input logic [11:0] addr, input logic [63:0] nv);
    case (addr)
        12'h300: shadow[addr] = nv & MSTATUS_MASK;
        12'h304: shadow[addr] = nv & MIE_MASK;
        12'h305: shadow[addr] = nv & ~64'h1;    // mtvec bit 0 low
        12'h341: shadow[addr] = nv & ~64'h3;    // mepc word aligned
        12'h301: ;                              // misa ignores writes
        default: shadow[addr] = nv;
    endcase
endtask

// One request on the falling edge, expectations set alongside
task automatic do_req(input logic [2:0] f3, input logic [11:0] addr, input logic [4:0] idx,
                      input logic [63:0] data, input logic check);
    logic [63:0] old;
    logic [63:0] operand;
    logic [63:0] nv;
    logic        ill;
    @(negedge clk_i);
    valid    = 1'b1;
    funct3   = f3;
    csr_addr = addr;
    rs1_idx  = idx;
    rs1_data = data;
    ill      = expect_illegal(f3, addr, idx);
    old      = read_model(addr);
    exp_valid   = 1'b1;
    exp_illegal = ill;
    exp_rdata   = ill ? 64'd0 : old;
    exp_check   = check;
    operand  = f3[2] ? {59'd0, idx} : data; // zimm form
    if (!ill && has_intent(f3, idx)) begin
        case (f3[1:0])
            2'b01:   nv = operand;
            2'b10:   nv = old | operand;
            default: nv = old & ~operand;
        endcase
        write_model(addr, nv);
    end
endtask

// Plain read through CSRRS with rs1 zero
task automatic read_csr(input logic [11:0] addr);
    do_req(3'd2, addr, 5'd0, 64'd0, 1'b1);
endtask

task automatic idle(input int n);
    int i;
    for (i = 0; i < n; i++) begin
        @(negedge clk_i);
        valid     = 1'b0;
        exp_valid = 1'b0;
    end
endtask

//--- bench/tb_csr_unit.sv
// Testbench top for the CSR unit with clock, reset, reference model, assertions and watchdog
`timescale 1ns/100ps

module tb_csr_unit import csr_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_REQS   = 84;             // Requests issued by the sequence

    logic        clk_i;
    logic        rst_i;
    logic        valid;
    logic [2:0]  funct3;
    logic [11:0] csr_addr;
    logic [4:0]  rs1_idx;
    logic [63:0] rs1_data;
    logic [0:0]  hartid;
    logic        instret;
    logic        done_o;
    logic [63:0] rdata_o;
    logic        illegal_o;

    logic        exp_valid;                     // Request driven this cycle
    logic        exp_illegal;
    logic [63:0] exp_rdata;
    logic        exp_check;                     // Compare rdata, off for mcycle
    logic [63:0] shadow [0:4095];               // Reference CSR contents
    logic [31:0] lfsr_state;

    `include "tb_csr_tasks.svh"

    csr_unit i_csr_unit (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .valid_i    (valid),
        .funct3_i   (funct3),
        .csr_addr_i (csr_addr),
        .rs1_idx_i  (rs1_idx),
        .rs1_data_i (rs1_data),
        .hartid_i   (hartid),
        .instret_i  (instret),
        .done_o     (done_o),
        .rdata_o    (rdata_o),
        .illegal_o  (illegal_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    task automatic fail_stop(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // Result one cycle after each request matches the model
    a_result: assert property (@(posedge clk_i) disable iff (rst_i)
        exp_valid |=> done_o && (illegal_o == $past(exp_illegal))
                      && (!$past(exp_check) || (rdata_o == $past(exp_rdata))))
        else fail_stop($sformatf("result mismatch, rdata %h illegal %b", rdata_o, illegal_o));

    a_no_extra_done: assert property (@(posedge clk_i) disable iff (rst_i)
        !exp_valid |=> !done_o)
        else fail_stop("done_o without a request");

    // Watchdog sized from the request budget
    initial begin
        #((NUM_REQS + 200) * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish in time");
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    initial begin
        logic [63:0] c1;
        logic [63:0] c2;
        logic [2:0]  f3;
        logic [11:0] addr;
        int          i;
        logic [11:0] rmw_addrs [5];
        rmw_addrs = '{12'h340, 12'h305, 12'h341, 12'h342, 12'h343};
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        valid       = 1'b0;
        funct3      = 3'd0;
        csr_addr    = '0;
        rs1_idx     = '0;
        rs1_data    = '0;
        hartid      = 1'b0;
        instret     = 1'b0;
        exp_valid   = 1'b0;
        exp_illegal = 1'b0;
        exp_rdata   = '0;
        exp_check   = 1'b0;
        lfsr_state  = 32'd7;
        for (i = 0; i < 4096; i++) begin
            shadow[i] = '0;
        end
        shadow[12'h301] = MISA_VALUE;
        shadow[12'hF11] = MVENDORID_VALUE;
        shadow[12'hF12] = MARCHID_VALUE;
        shadow[12'hF13] = MIMPID_VALUE;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        a_reset: assert (!done_o && !illegal_o && rdata_o == '0)
            else fail_stop("outputs not cleared by reset");

        // Identification registers, both harts
        read_csr(12'hF11);
        read_csr(12'hF12);
        read_csr(12'hF13);
        read_csr(12'hF14);
        do_req(3'd2, 12'hF14, 5'd0, 64'd0, 1'b1);
        idle(1);
        hartid = 1'b1;                          // Second hart from here on
        read_csr(12'hF14);

        // Random read-modify-write, mostly back-to-back
        for (i = 0; i < 60; i++) begin
            addr = rmw_addrs[3'(rand_bits(3) % 5)];
            f3   = 3'(rand_bits(3));
            if (f3[1:0] == 2'b00) begin
                f3 = f3 | 3'd1;
            end
            do_req(f3, addr, 5'(rand_bits(5)), rand_bits(64), 1'b1);
            if (rand_bits(2) == 0) begin
                idle(1);
            end
        end

        // Field masks and WARL misa
        do_req(3'd1, 12'h300, 5'd1, '1, 1'b1);
        read_csr(12'h300);
        do_req(3'd1, 12'h304, 5'd1, '1, 1'b1);
        read_csr(12'h304);
        do_req(3'd1, 12'h301, 5'd1, '1, 1'b1);
        read_csr(12'h301);
        idle(1);

        // Illegal requests leave the target unchanged
        do_req(3'd0, 12'h340, 5'd3, 64'hDEAD, 1'b1);
        do_req(3'd4, 12'h340, 5'd3, 64'hBEEF, 1'b1);
        read_csr(12'h340);
        do_req(3'd1, 12'h7C0, 5'd3, 64'h1234, 1'b1);
        do_req(3'd1, 12'hF11, 5'd3, 64'h5555, 1'b1);
        read_csr(12'hF11);
        do_req(3'd2, 12'hF14, 5'd0, '1, 1'b1);

        // mcycle reads five cycles apart
        do_req(3'd2, 12'hB00, 5'd0, 64'd0, 1'b0);
        idle(1);
        c1 = rdata_o;
        idle(3);
        do_req(3'd2, 12'hB00, 5'd0, 64'd0, 1'b0);
        idle(1);
        c2 = rdata_o;
        a_mcycle: assert (c2 - c1 == 64'd5)
            else fail_stop($sformatf("mcycle step %0d, expected 5", c2 - c1));

        // minstret write then three pulses, read alongside a fourth
        do_req(3'd1, 12'hB02, 5'd1, 64'h100, 1'b0);
        idle(1);
        instret = 1'b1;
        idle(2);
        shadow[12'hB02] = 64'h103;
        read_csr(12'hB02);                      // Fourth pulse in the read cycle
        idle(1);
        instret = 1'b0;
        shadow[12'hB02] = 64'h104;
        read_csr(12'hB02);
        idle(2);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- src.f
common/csr_pkg.sv
common/csr_req_if.sv
src/csr_decode.sv
csr_regs/csr_regs.sv
src/csr_alu.sv
src/csr_result.sv
src/csr_unit.sv
+incdir+bench
bench/tb_csr_unit.sv
